// File: tb.f
source/mipsPkg.sv
source/ctrlIf.sv
source/controlUnit.sv
source/pcSequencer.sv
source/busMaster.sv
source/registerFile.sv
source/alu.sv
source/mipsCpu.sv
tests/mipsCpuTb.sv

// File: Makefile
# Verilator build and run for the MIPS CPU testbench

VERILATOR ?= verilator
TOP       ?= mipsCpuTb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/mipsCpuTb.sv
// Multicycle MIPS CPU testbench
`timescale 1ns/10ps
module mipsCpuTb;

    localparam logic [31:0] RESET_VECTOR = 32'hBFC00000;
    localparam logic [31:0] DATA_BASE    = 32'h00001000;   // Aligned to the data region size
    localparam int CODE_AW        = 6;                     // 64 code words
    localparam int DATA_AW        = 5;                     // 32 data words
    localparam int PROG_LEN       = 33;
    localparam int PERIOD         = 20;
    localparam int RESET_CYCLES   = 16;
    localparam int MAX_WAIT       = 3;                     // Longest waitrequest run
    localparam int HALT_CYCLES    = 8;                     // Idle cycles watched after halt
    localparam int MAX_STEPS      = 1000;
    localparam int TIMEOUT_CYCLES =
        2 * (RESET_CYCLES + HALT_CYCLES + PROG_LEN * 4 * (MAX_WAIT + 1)) + 100;

    localparam logic [4:0] R0 = 5'd0;
    localparam logic [4:0] V0 = 5'd2;
    localparam logic [4:0] T0 = 5'd8;
    localparam logic [4:0] T1 = 5'd9;
    localparam logic [4:0] T2 = 5'd10;
    localparam logic [4:0] T3 = 5'd11;
    localparam logic [4:0] T5 = 5'd13;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        waitrequest = 1'b0;
    logic [31:0] readdata;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic        active;
    logic [31:0] registerV0;

    logic [31:0] codeMem [1 << CODE_AW];
    logic [31:0] dataMem [1 << DATA_AW];
    logic [31:0] lcgState = 32'he110_ba10;
    logic        randomWaits = 1'b0;   // Second pass only
    int          waitRun = 0;
    int          cycle = 0;

    logic [31:0] expFetch [$];         // Predicted fetch addresses
    logic [31:0] expV0 [$];            // v0 seen at each fetch
    logic [31:0] expWrAddr [$];
    logic [31:0] expWrData [$];
    logic [31:0] expFinalV0;

    int          fetchIdx = 0;
    int          writeIdx = 0;
    int          lastFetchCycle = 0;
    logic        prevPending = 1'b0;   // Request stalled last cycle
    logic        prevRead;
    logic        prevWrite;
    logic [31:0] prevAddr;
    logic [31:0] prevData;
    int          mismatchCount = 0;
    int          failureCount = 0;

    function automatic logic [31:0] rFormat(input logic [5:0] fn, input logic [4:0] rd,
                                            input logic [4:0] rs, input logic [4:0] rt);
        return {mipsPkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iFormat(input logic [5:0] op, input logic [4:0] rt,
                                            input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jFormat(input logic [31:0] target);
        return {mipsPkg::OP_J, target[27:2]};   // Byte address in, word index out
    endfunction

    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'hA5C3_0F69;   // Unwritten memory
    endfunction

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic codeHit(input logic [31:0] addr);
        return addr[31:CODE_AW+2] == RESET_VECTOR[31:CODE_AW+2];
    endfunction

    function automatic logic dataHit(input logic [31:0] addr);
        return addr[31:DATA_AW+2] == DATA_BASE[31:DATA_AW+2];
    endfunction

    // Instruction-level model, fills the prediction queues
    function automatic logic [31:0] runReference();
        logic [31:0] regs [32];
        logic [31:0] mem [1 << DATA_AW];
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic [31:0] instr;
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [4:0]  rt;
        logic [4:0]  rd;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < (1 << DATA_AW); i++) begin
            mem[i] = fillWord(DATA_BASE + (32'(i) << 2));
        end
        pc = RESET_VECTOR;
        steps = 0;
        while (pc != '0 && steps < MAX_STEPS) begin
            expFetch.push_back(pc);
            expV0.push_back(regs[2]);
            instr = codeHit(pc) ? codeMem[pc[CODE_AW+1:2]] : fillWord(pc);
            rt = instr[20:16];
            rd = instr[15:11];
            a = regs[instr[25:21]];
            b = regs[rt];
            imm = {{16{instr[15]}}, instr[15:0]};
            addr = a + imm;
            nextPc = pc + 32'd4;                        // No delay slot
            case (instr[31:26])
                mipsPkg::OP_RTYPE: begin
                    case (instr[5:0])
                        mipsPkg::FN_ADDU: regs[rd] = a + b;
                        mipsPkg::FN_SUBU: regs[rd] = a - b;
                        mipsPkg::FN_AND:  regs[rd] = a & b;
                        mipsPkg::FN_OR:   regs[rd] = a | b;
                        mipsPkg::FN_XOR:  regs[rd] = a ^ b;
                        mipsPkg::FN_SLT:  regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        mipsPkg::FN_SLTU: regs[rd] = (a < b) ? 32'd1 : 32'd0;
                        mipsPkg::FN_JR:   nextPc = a;
                        default:          ;
                    endcase
                end
                mipsPkg::OP_ADDIU: regs[rt] = addr;
                mipsPkg::OP_LW: begin
                    if (dataHit(addr)) begin
                        regs[rt] = mem[addr[DATA_AW+1:2]];
                    end else begin
                        regs[rt] = codeHit(addr) ? codeMem[addr[CODE_AW+1:2]] : fillWord(addr);
                    end
                end
                mipsPkg::OP_SW: begin
                    expWrAddr.push_back(addr);
                    expWrData.push_back(b);
                    if (dataHit(addr)) begin
                        mem[addr[DATA_AW+1:2]] = b;
                    end
                end
                mipsPkg::OP_BEQ: begin
                    if (a == b) begin
                        nextPc = nextPc + (imm << 2);
                    end
                end
                mipsPkg::OP_J: nextPc = {nextPc[31:28], instr[25:0], 2'b00};
                default: ;                              // Treated as NOP
            endcase
            regs[0] = '0;
            pc = nextPc;
            steps++;
        end
        return regs[2];
    endfunction

    task automatic loadProgram();
        for (int i = 0; i < (1 << CODE_AW); i++) begin
            codeMem[i] = fillWord(RESET_VECTOR + (32'(i) << 2));
        end
        codeMem[0]  = iFormat(mipsPkg::OP_ADDIU, T0, R0, 16'h1000);   // Data base
        codeMem[1]  = iFormat(mipsPkg::OP_ADDIU, T1, R0, 16'h1234);
        codeMem[2]  = iFormat(mipsPkg::OP_ADDIU, T2, R0, 16'hFFFB);   // Minus five
        codeMem[3]  = rFormat(mipsPkg::FN_ADDU, V0, T1, T2);
        codeMem[4]  = iFormat(mipsPkg::OP_SW, V0, T0, 16'h0000);
        codeMem[5]  = rFormat(mipsPkg::FN_SUBU, V0, T1, T2);
        codeMem[6]  = iFormat(mipsPkg::OP_SW, V0, T0, 16'h0004);
        codeMem[7]  = rFormat(mipsPkg::FN_AND, V0, T1, T2);
        codeMem[8]  = iFormat(mipsPkg::OP_SW, V0, T0, 16'h0008);
        codeMem[9]  = rFormat(mipsPkg::FN_OR, V0, T1, T2);
        codeMem[10] = iFormat(mipsPkg::OP_SW, V0, T0, 16'h000C);
        codeMem[11] = rFormat(mipsPkg::FN_XOR, V0, T1, T2);
        codeMem[12] = iFormat(mipsPkg::OP_SW, V0, T0, 16'h0010);
        codeMem[13] = rFormat(mipsPkg::FN_SLT, V0, T2, T1);           // Signed, true
        codeMem[14] = iFormat(mipsPkg::OP_SW, V0, T0, 16'h0014);
        codeMem[15] = rFormat(mipsPkg::FN_SLTU, V0, T2, T1);          // Unsigned, false
        codeMem[16] = iFormat(mipsPkg::OP_SW, V0, T0, 16'h0018);
        codeMem[17] = iFormat(mipsPkg::OP_ADDIU, V0, T1, 16'hFFCC);
        codeMem[18] = iFormat(mipsPkg::OP_SW, V0, T0, 16'h001C);
        codeMem[19] = iFormat(mipsPkg::OP_LW, V0, T0, 16'h0004);      // Round trip of SUBU
        codeMem[20] = iFormat(mipsPkg::OP_LW, T3, T0, 16'h0040);      // Untouched word
        codeMem[21] = iFormat(mipsPkg::OP_BEQ, T3, V0, 16'h0001);     // Not taken
        codeMem[22] = iFormat(mipsPkg::OP_ADDIU, V0, V0, 16'h0001);
        codeMem[23] = iFormat(mipsPkg::OP_BEQ, T1, T1, 16'h0002);     // Taken, skips two
        codeMem[24] = iFormat(mipsPkg::OP_ADDIU, V0, R0, 16'h7777);
        codeMem[25] = iFormat(mipsPkg::OP_ADDIU, V0, R0, 16'h6666);
        codeMem[26] = jFormat(RESET_VECTOR + 32'd116);                // To word 29
        codeMem[27] = iFormat(mipsPkg::OP_ADDIU, V0, R0, 16'h5555);
        codeMem[28] = iFormat(mipsPkg::OP_ADDIU, V0, R0, 16'h4444);
        codeMem[29] = iFormat(mipsPkg::OP_SW, V0, T0, 16'h0020);
        codeMem[30] = rFormat(mipsPkg::FN_SUBU, T5, T1, T1);          // t5 is zero
        codeMem[31] = rFormat(mipsPkg::FN_JR, R0, T5, R0);            // Jump to 0 halts
        codeMem[32] = iFormat(mipsPkg::OP_ADDIU, V0, R0, 16'h3333);
    endtask

    task automatic countMismatch(input string msg);
        mismatchCount++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    task automatic logFailure(input string msg);
        failureCount++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic finishRun();
        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
        if (mismatchCount + failureCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic applyReset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
    endtask

    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    mipsCpu #(
        .RESET_VECTOR (RESET_VECTOR)
    ) i_mipsCpu (
        .clk         (clk),
        .rst         (rst),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .active      (active),
        .registerV0  (registerV0)
    );

    // Memory answers in the cycle of the request
    always_comb begin
        if (codeHit(address)) begin
            readdata = codeMem[address[CODE_AW+1:2]];
        end else if (dataHit(address)) begin
            readdata = dataMem[address[DATA_AW+1:2]];
        end else begin
            readdata = fillWord(address);
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << DATA_AW); i++) begin
                dataMem[i] <= fillWord(DATA_BASE + (32'(i) << 2));
            end
        end else if (write && !waitrequest && dataHit(address)) begin
            dataMem[address[DATA_AW+1:2]] <= writedata;   // Store completes
        end
    end

    // Random back-pressure, runs capped at MAX_WAIT
    always @(posedge clk) begin
        if (rst || !randomWaits || waitRun >= MAX_WAIT) begin
            waitrequest <= 1'b0;
            waitRun     <= 0;
        end else begin
            waitrequest <= lcgState[31];
            waitRun     <= lcgState[31] ? waitRun + 1 : 0;
        end
        lcgState <= nextRandom(lcgState);
    end

    // Compare bus activity mid-cycle, where everything is settled
    always @(negedge clk) begin
        if (rst) begin
            fetchIdx    = 0;
            writeIdx    = 0;
            prevPending = 1'b0;
        end else begin
            if (prevPending) begin
                assert (address == prevAddr && read == prevRead && write == prevWrite &&
                        writedata == prevData)
                else countMismatch($sformatf("request moved to %h during waitrequest", address));
            end
            if (read && !waitrequest && codeHit(address)) begin
                assert (fetchIdx < expFetch.size())
                else logFailure($sformatf("fetch at %h after the predicted halt", address));
                if (fetchIdx < expFetch.size()) begin
                    assert (address == expFetch[fetchIdx])
                    else countMismatch($sformatf("fetch %0d at %h, expected %h",
                                                 fetchIdx, address, expFetch[fetchIdx]));
                    assert (registerV0 == expV0[fetchIdx])
                    else countMismatch($sformatf("v0 %h at fetch %0d, expected %h",
                                                 registerV0, fetchIdx, expV0[fetchIdx]));
                end
                if (!randomWaits && fetchIdx > 0) begin
                    assert (cycle - lastFetchCycle == 4)
                    else countMismatch($sformatf("instruction took %0d cycles, expected 4",
                                                 cycle - lastFetchCycle));
                end
                lastFetchCycle = cycle;
                fetchIdx++;
            end
            if (write && !waitrequest) begin
                assert (writeIdx < expWrAddr.size())
                else logFailure($sformatf("store to %h that the program never makes", address));
                if (writeIdx < expWrAddr.size()) begin
                    assert (address == expWrAddr[writeIdx] && writedata == expWrData[writeIdx])
                    else countMismatch($sformatf("store %0d wrote %h to %h, expected %h to %h",
                                                 writeIdx, writedata, address,
                                                 expWrData[writeIdx], expWrAddr[writeIdx]));
                end
                writeIdx++;
            end
            if (!active) begin
                assert (!read && !write)
                else logFailure("bus request issued while the CPU is halted");
            end
            prevPending = (read || write) && waitrequest;
            prevRead    = read;
            prevWrite   = write;
            prevAddr    = address;
            prevData    = writedata;
        end
    end

    initial begin
        loadProgram();
        expFinalV0 = runReference();
        // Pass 0 without waits, pass 1 with random waitrequest
        for (int pass = 0; pass < 2; pass++) begin
            randomWaits = (pass == 1);
            applyReset();
            assert (active) else countMismatch("active low after reset");
            while (active) @(negedge clk);
            repeat (HALT_CYCLES) @(negedge clk);
            assert (registerV0 == expFinalV0)
            else countMismatch($sformatf("final v0 %h, expected %h", registerV0, expFinalV0));
            assert (fetchIdx == expFetch.size())
            else logFailure($sformatf("pass %0d saw %0d of %0d predicted fetches",
                                      pass, fetchIdx, expFetch.size()));
            assert (writeIdx == expWrAddr.size())
            else logFailure($sformatf("pass %0d saw %0d of %0d predicted stores",
                                      pass, writeIdx, expWrAddr.size()));
        end
        finishRun();
    end

    // Watchdog sized from the program length and the worst wait runs
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        logFailure($sformatf("timeout, the CPU did not halt within %0d cycles", TIMEOUT_CYCLES));
        finishRun();
    end

endmodule

// File: source/mipsCpu.sv
// Multicycle MIPS CPU top level
`timescale 1ns/10ps
module mipsCpu #(
    parameter logic [mipsPkg::WORD_W-1:0] RESET_VECTOR = mipsPkg::RESET_VECTOR
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        waitrequest,
    input  logic [mipsPkg::WORD_W-1:0]  readdata,
    output logic [mipsPkg::WORD_W-1:0]  address,
    output logic                        read,
    output logic                        write,
    output logic [mipsPkg::WORD_W-1:0]  writedata,
    output logic                        active,
    output logic [mipsPkg::WORD_W-1:0]  registerV0
);

    mipsPkg::cpuState_e         state;
    logic [mipsPkg::WORD_W-1:0] pc;
    logic [mipsPkg::WORD_W-1:0] instr;        // Instruction register
    logic [mipsPkg::WORD_W-1:0] loadData;     // Last completed read
    logic [mipsPkg::WORD_W-1:0] rsData;
    logic [mipsPkg::WORD_W-1:0] rtData;
    logic [mipsPkg::WORD_W-1:0] aluResult;
    logic                       zero;

    ctrlIf ctrlBus ();

    controlUnit i_controlUnit (
        .opcode (instr[31:26]),
        .funct  (instr[5:0]),
        .state  (state),
        .ctrl   (ctrlBus.ctrl)
    );

    pcSequencer #(
        .RESET_VECTOR (RESET_VECTOR)
    ) i_pcSequencer (
        .clk         (clk),
        .rst         (rst),
        .waitrequest (waitrequest),
        .instr       (instr),
        .rsData      (rsData),
        .zero        (zero),
        .ctrl        (ctrlBus.dp),
        .state       (state),
        .pc          (pc),
        .active      (active)
    );

    busMaster i_busMaster (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .aluResult   (aluResult),
        .rtData      (rtData),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .ctrl        (ctrlBus.dp),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .instr       (instr),
        .loadData    (loadData)
    );

    registerFile i_registerFile (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .aluResult  (aluResult),
        .loadData   (loadData),
        .ctrl       (ctrlBus.dp),
        .rsData     (rsData),
        .rtData     (rtData),
        .registerV0 (registerV0)
    );

    alu i_alu (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .rsData    (rsData),
        .rtData    (rtData),
        .ctrl      (ctrlBus.dp),
        .aluResult (aluResult),
        .zero      (zero)
    );

endmodule

// File: source/alu.sv
// Arithmetic and logic unit
`timescale 1ns/10ps
module alu (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [mipsPkg::WORD_W-1:0]  instr,
    input  logic [mipsPkg::WORD_W-1:0]  rsData,
    input  logic [mipsPkg::WORD_W-1:0]  rtData,
    ctrlIf.dp                           ctrl,
    output logic [mipsPkg::WORD_W-1:0]  aluResult,
    output logic                        zero
);

    logic [mipsPkg::WORD_W-1:0] opB;
    logic [mipsPkg::WORD_W-1:0] resultComb;
    logic [mipsPkg::WORD_W-1:0] resultReg;
    logic                       lessSigned;
    logic                       lessUnsigned;

    assign opB          = ctrl.aluSrc ? {{16{instr[15]}}, instr[15:0]} : rtData;
    assign lessSigned   = $signed(rsData) < $signed(opB);
    assign lessUnsigned = rsData < opB;

    always_comb begin
        case (ctrl.aluOp)
            mipsPkg::ADD: resultComb = rsData + opB;
            mipsPkg::SUB: resultComb = rsData - opB;
            default: begin
                case (instr[5:0])                          // Function field decode
                    mipsPkg::FN_SUBU: resultComb = rsData - opB;
                    mipsPkg::FN_AND:  resultComb = rsData & opB;
                    mipsPkg::FN_OR:   resultComb = rsData | opB;
                    mipsPkg::FN_XOR:  resultComb = rsData ^ opB;
                    mipsPkg::FN_SLT:  resultComb = {{(mipsPkg::WORD_W-1){1'b0}}, lessSigned};
                    mipsPkg::FN_SLTU: resultComb = {{(mipsPkg::WORD_W-1){1'b0}}, lessUnsigned};
                    default:          resultComb = rsData + opB;   // ADDU and JR
                endcase
            end
        endcase
    end

    // Captured in execute states, operands stay fixed until write-back
    always_ff @(posedge clk) begin
        if (!ctrl.pcToAddr) begin
            resultReg <= resultComb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            zero <= 1'b0;
        end else if (!ctrl.pcToAddr) begin
            zero <= (resultComb == '0);    // BEQ decision in EXEC2
        end
    end

    // LW address is needed within EXEC1, before the register is loaded
    assign aluResult = ctrl.memRead ? resultComb : resultReg;

endmodule

// File: source/registerFile.sv
// General purpose registers
`timescale 1ns/10ps
module registerFile (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [mipsPkg::WORD_W-1:0]  instr,
    input  logic [mipsPkg::WORD_W-1:0]  aluResult,
    input  logic [mipsPkg::WORD_W-1:0]  loadData,
    ctrlIf.dp                           ctrl,
    output logic [mipsPkg::WORD_W-1:0]  rsData,
    output logic [mipsPkg::WORD_W-1:0]  rtData,
    output logic [mipsPkg::WORD_W-1:0]  registerV0
);

    logic [mipsPkg::WORD_W-1:0] regs [32];
    logic [4:0]                 writeAddr;
    logic [mipsPkg::WORD_W-1:0] writeData;

    assign writeAddr = ctrl.regDst ? instr[15:11] : instr[20:16];   // rd or rt
    assign writeData = ctrl.memToReg ? loadData : aluResult;

    // Combinational read, r0 reads zero since it is never written
    assign rsData     = regs[instr[25:21]];
    assign rtData     = regs[instr[20:16]];
    assign registerV0 = regs[2];                                    // v0 tap

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && (writeAddr != 5'd0)) begin
            regs[writeAddr] <= writeData;     // End of EXEC2
        end
    end

endmodule

// File: source/busMaster.sv
// Avalon-MM master and fetch latches
`timescale 1ns/10ps
module busMaster (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [mipsPkg::WORD_W-1:0]  pc,
    input  logic [mipsPkg::WORD_W-1:0]  aluResult,
    input  logic [mipsPkg::WORD_W-1:0]  rtData,
    input  logic [mipsPkg::WORD_W-1:0]  readdata,
    input  logic                        waitrequest,
    ctrlIf.dp                           ctrl,
    output logic [mipsPkg::WORD_W-1:0]  address,
    output logic                        read,
    output logic                        write,
    output logic [mipsPkg::WORD_W-1:0]  writedata,
    output logic [mipsPkg::WORD_W-1:0]  instr,
    output logic [mipsPkg::WORD_W-1:0]  loadData
);

    // Request signals come straight from decode and stay put while stalled
    assign address   = ctrl.pcToAddr ? pc : aluResult;
    assign read      = ctrl.memRead;
    assign write     = ctrl.memWrite;
    assign writedata = rtData;                   // SW source register

    // Read data is valid in the completing cycle only
    always_ff @(posedge clk) begin
        if (ctrl.memRead && !waitrequest) begin
            loadData <= readdata;                // Instruction or LW word
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instr <= '0;                         // Decodes as a harmless R-type
        end else if (ctrl.instrWrite) begin
            instr <= loadData;                   // IR load in DECODE
        end
    end

endmodule

// File: source/pcSequencer.sv
// State register and program counter
`timescale 1ns/10ps
module pcSequencer #(
    parameter logic [mipsPkg::WORD_W-1:0] RESET_VECTOR = mipsPkg::RESET_VECTOR
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        waitrequest,
    input  logic [mipsPkg::WORD_W-1:0]  instr,
    input  logic [mipsPkg::WORD_W-1:0]  rsData,
    input  logic                        zero,
    ctrlIf.dp                           ctrl,
    output mipsPkg::cpuState_e          state,
    output logic [mipsPkg::WORD_W-1:0]  pc,
    output logic                        active
);

    logic [5:0]                 opcode;
    logic                       busPending;     // Current state owns a transfer
    logic                       stall;
    logic                       pcWrite;
    logic [mipsPkg::WORD_W-1:0] pcPlus4;
    logic [mipsPkg::WORD_W-1:0] branchOffset;
    logic [mipsPkg::WORD_W-1:0] nextPc;
    mipsPkg::cpuState_e         nextState;

    assign opcode     = instr[31:26];
    assign busPending = (state == mipsPkg::FETCH) ||
                        ((state == mipsPkg::EXEC1) && (opcode == mipsPkg::OP_LW)) ||
                        ((state == mipsPkg::EXEC2) && (opcode == mipsPkg::OP_SW));
    assign stall      = busPending && waitrequest;
    assign pcWrite    = (state == mipsPkg::EXEC2) && !stall;

    assign pcPlus4      = pc + 32'd4;
    assign branchOffset = {{14{instr[15]}}, instr[15:0], 2'b00};   // Word offset, sign extended

    always_comb begin
        if (ctrl.jump && ctrl.regJump) begin
            nextPc = rsData;                                       // JR
        end else if (ctrl.jump) begin
            nextPc = {pcPlus4[31:28], instr[25:0], 2'b00};         // J, region of PC+4
        end else if (ctrl.branch && zero) begin
            nextPc = pcPlus4 + branchOffset;                       // BEQ taken, no delay slot
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            mipsPkg::HALT:   nextState = active ? mipsPkg::FETCH : mipsPkg::HALT;  // Start once
            mipsPkg::FETCH:  nextState = mipsPkg::DECODE;
            mipsPkg::DECODE: nextState = mipsPkg::EXEC1;
            mipsPkg::EXEC1:  nextState = mipsPkg::EXEC2;
            mipsPkg::EXEC2:  nextState = (nextPc == '0) ? mipsPkg::HALT : mipsPkg::FETCH;
            default:         nextState = mipsPkg::HALT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= mipsPkg::HALT;     // Halted but armed, no bus request during reset
            pc     <= RESET_VECTOR;
            active <= 1'b1;
        end else begin
            if (!stall) begin
                state <= nextState;      // Frozen while waitrequest holds a transfer
            end
            if (pcWrite) begin
                pc <= nextPc;
                if (nextPc == '0) begin
                    active <= 1'b0;      // Jump to zero ends the run
                end
            end
        end
    end

endmodule

// File: source/controlUnit.sv
// Instruction decode and control
`timescale 1ns/10ps
module controlUnit (
    input  logic [5:0]          opcode,
    input  logic [5:0]          funct,
    input  mipsPkg::cpuState_e  state,
    ctrlIf.ctrl                 ctrl
);

    logic exec1;      // LW read state
    logic exec2;      // Write-back state
    logic arith;      // R-type writing rd
    logic isJr;       // Register jump

    assign exec1 = (state == mipsPkg::EXEC1);
    assign exec2 = (state == mipsPkg::EXEC2);

    assign arith = (funct == mipsPkg::FN_ADDU) || (funct == mipsPkg::FN_SUBU) ||
                   (funct == mipsPkg::FN_AND)  || (funct == mipsPkg::FN_OR)   ||
                   (funct == mipsPkg::FN_XOR)  || (funct == mipsPkg::FN_SLT)  ||
                   (funct == mipsPkg::FN_SLTU);
    assign isJr  = (funct == mipsPkg::FN_JR);

    always_comb begin
        // Quiet defaults, nothing stored anywhere
        ctrl.aluOp      = mipsPkg::ADD;
        ctrl.aluSrc     = 1'b0;
        ctrl.jump       = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.regJump    = 1'b0;
        ctrl.memRead    = 1'b0;
        ctrl.memWrite   = 1'b0;
        ctrl.regDst     = 1'b0;
        ctrl.memToReg   = 1'b0;
        ctrl.regWrite   = 1'b0;
        ctrl.instrWrite = 1'b0;
        ctrl.pcToAddr   = 1'b0;

        case (state)
            mipsPkg::HALT: begin
                ctrl.pcToAddr = 1'b1;            // Bus idle, address parked on PC
            end
            mipsPkg::FETCH: begin
                ctrl.memRead  = 1'b1;            // Read instruction word
                ctrl.pcToAddr = 1'b1;
            end
            mipsPkg::DECODE: begin
                ctrl.instrWrite = 1'b1;          // Latched word into IR
                ctrl.pcToAddr   = 1'b1;
            end
            default: begin
                case (opcode)
                    mipsPkg::OP_RTYPE: begin
                        ctrl.aluOp    = mipsPkg::FUNCT;   // Function field picks op
                        ctrl.regDst   = 1'b1;             // Write rd
                        ctrl.regWrite = arith & exec2;    // JR writes nothing
                        ctrl.jump     = isJr;
                        ctrl.regJump  = isJr;
                    end
                    mipsPkg::OP_ADDIU: begin
                        ctrl.aluSrc   = 1'b1;
                        ctrl.regWrite = exec2;
                    end
                    mipsPkg::OP_LW: begin
                        ctrl.aluSrc   = 1'b1;             // Base plus offset
                        ctrl.memRead  = exec1;
                        ctrl.memToReg = 1'b1;
                        ctrl.regWrite = exec2;
                    end
                    mipsPkg::OP_SW: begin
                        ctrl.aluSrc   = 1'b1;
                        ctrl.memWrite = exec2;            // Address from registered result
                    end
                    mipsPkg::OP_BEQ: begin
                        ctrl.aluOp  = mipsPkg::SUB;       // Zero when rs equals rt
                        ctrl.branch = 1'b1;
                    end
                    mipsPkg::OP_J: begin
                        ctrl.jump = 1'b1;
                    end
                    default: begin
                        ctrl.regWrite = 1'b0;             // Unsupported, runs as NOP
                    end
                endcase
            end
        endcase
    end

endmodule

// File: source/ctrlIf.sv
// Datapath control bundle
`timescale 1ns/10ps
interface ctrlIf;

    mipsPkg::aluOp_e aluOp;    // ALU operation class
    logic aluSrc;              // Immediate as operand B
    logic jump;                // J or JR taken
    logic branch;              // BEQ, taken on zero
    logic regJump;             // Target from rs
    logic memRead;             // Bus read request
    logic memWrite;            // Bus write request
    logic regDst;              // Destination rd, else rt
    logic memToReg;            // Write-back from load data
    logic regWrite;            // Register file write enable
    logic instrWrite;          // Instruction register load
    logic pcToAddr;            // Bus address from PC

    modport ctrl (output aluOp, aluSrc, jump, branch, regJump, memRead, memWrite,
                  regDst, memToReg, regWrite, instrWrite, pcToAddr);
    modport dp (input aluOp, aluSrc, jump, branch, regJump, memRead, memWrite,
                regDst, memToReg, regWrite, instrWrite, pcToAddr);

endinterface

// File: source/mipsPkg.sv
// MIPS subset definitions
package mipsPkg;

    localparam int WORD_W = 32;                                  // Data and address width
    localparam logic [WORD_W-1:0] RESET_VECTOR = 32'hBFC00000;   // Default boot address

    // Sequencer states with HALT at zero
    typedef enum logic [2:0] {
        HALT   = 3'd0,    // Idle with no bus traffic
        FETCH  = 3'd1,    // Instruction read at PC
        DECODE = 3'd2,    // Instruction register load
        EXEC1  = 3'd3,    // ALU and LW read
        EXEC2  = 3'd4     // Write-back, SW, PC update
    } cpuState_e;

    typedef enum logic [1:0] {
        ADD   = 2'b00,    // Address calc and ADDIU
        SUB   = 2'b01,    // BEQ compare
        FUNCT = 2'b10     // Function field decides
    } aluOp_e;

    // Primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_ADDIU = 6'b001001;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_SW    = 6'b101011;
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    localparam logic [5:0] OP_J     = 6'b000010;

    // R-type function codes
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;
    localparam logic [5:0] FN_JR   = 6'b001000;

endpackage
